// File: rtl/chip_pkg.sv
/*
 * pad counts, MIO/DIO pad indices and the GPIO pad table
 * pad attribute struct, power-on constants and phase enum
 */
package chip_pkg;

  //////////////////////////////////////////////////
  // pad counts
  //////////////////////////////////////////////////
  localparam int NMioPads  = 47;
  localparam int NDioPads  = 16;
  localparam int GpioWidth = 32;

  // multiplexed pads, bottom row
  localparam int MioPadIob6  = 13;
  localparam int MioPadIob7  = 14;
  localparam int MioPadIob8  = 15;
  localparam int MioPadIob9  = 16;
  localparam int MioPadIob10 = 17;
  localparam int MioPadIob11 = 18;
  localparam int MioPadIob12 = 19;

  // multiplexed pads, right row
  localparam int MioPadIor5  = 37;
  localparam int MioPadIor6  = 38;
  localparam int MioPadIor7  = 39;
  localparam int MioPadIor10 = 40;
  localparam int MioPadIor11 = 41;
  localparam int MioPadIor12 = 42;
  localparam int MioPadIor13 = 43;

  // multiplexed pads, corner row (straps, uart, usb sense)
  localparam int MioPadIoc0 = 22;
  localparam int MioPadIoc1 = 23;
  localparam int MioPadIoc2 = 24;
  localparam int MioPadIoc3 = 25;
  localparam int MioPadIoc4 = 26;
  localparam int MioPadIoc5 = 27;
  localparam int MioPadIoc6 = 28;
  localparam int MioPadIoc7 = 29;
  localparam int MioPadIoc8 = 30;

  // gpio bit -> mio pad, only valid under the mask
  localparam int GpioPadIdx [GpioWidth] = '{
    MioPadIob6, MioPadIob7, MioPadIob8, MioPadIob9,
    MioPadIob10, MioPadIob11, MioPadIob12,
    MioPadIor5, MioPadIor6, MioPadIor7, MioPadIor10,
    MioPadIor11, MioPadIor12, MioPadIor13,
    0, 0, 0, 0, 0, 0, 0, 0,
    MioPadIoc0, MioPadIoc1, MioPadIoc2,
    0, 0,
    MioPadIoc5,
    0, 0,
    MioPadIoc8,
    0
  };

  // bits 0..13, 22..24, 27 and 30
  localparam logic [GpioWidth-1:0] GpioUsedMask = 32'h49C0_3FFF;

  // dedicated pads
  localparam int DioUsbDn  = 0;
  localparam int DioUsbDp  = 1;
  localparam int DioSpiSck = 12;
  localparam int DioSpiCsb = 13;
  localparam int DioSpiSd0 = 14;
  localparam int DioSpiSd1 = 15;

  typedef struct packed {
    logic pull_en;
    logic pull_select;
  } pad_attr_t;

  //////////////////////////////////////////////////
  // power-on sequence
  //////////////////////////////////////////////////
  localparam int PorCntMax      = 15;
  localparam int SupplyRiseCnt  = 4;
  localparam int SupplyDipStart = 8;
  localparam int SupplyDipEnd   = 12;
  localparam int MainPokDelay   = 8;

  typedef enum logic [1:0] {
    PHASE_RAMP,
    PHASE_FIRST_ON,
    PHASE_DIP,
    PHASE_STABLE
  } por_phase_e;

endpackage

// File: rtl/pad_drive_if.sv
/*
 * pad-side drive values from the MIO and DIO maps to the output gate
 */
`timescale 1ns/1ps

interface pad_drive_if import chip_pkg::*; ();

  // gpio and uart, from the mio map
  logic [GpioWidth-1:0] gpio_d;
  logic [GpioWidth-1:0] gpio_en;
  logic [GpioWidth-1:0] gpio_pull_en;
  logic [GpioWidth-1:0] gpio_pull_sel;
  logic                 uart_tx;
  logic                 uart_tx_en;

  // spi and usb, from the dio map
  logic spi_sdo;
  logic spi_sdo_en;
  logic usb_dp;
  logic usb_dp_en;
  logic usb_dn;
  logic usb_dn_en;
  logic usb_d_en;

  modport mio_src (
    output gpio_d, gpio_en, gpio_pull_en, gpio_pull_sel, uart_tx, uart_tx_en
  );

  modport dio_src (
    output spi_sdo, spi_sdo_en, usb_dp, usb_dp_en, usb_dn, usb_dn_en, usb_d_en
  );

  modport gate (
    input gpio_d, gpio_en, gpio_pull_en, gpio_pull_sel, uart_tx, uart_tx_en,
    input spi_sdo, spi_sdo_en, usb_dp, usb_dp_en, usb_dn, usb_dn_en, usb_d_en
  );

endinterface

// File: rtl/mio_pad_map.sv
/*
 * multiplexed pad routing for gpio, uart and usb sense, both directions
 */
`timescale 1ns/1ps

module mio_pad_map import chip_pkg::*; (
  input  logic      [NMioPads-1:0]  mio_out_i,
  input  logic      [NMioPads-1:0]  mio_oe_i,
  input  pad_attr_t [NMioPads-1:0]  mio_attr_i,
  input  logic      [GpioWidth-1:0] gpio_p2d_i,
  input  logic                      uart_rx_p2d_i,
  input  logic                      usb_sense_p2d_i,
  output logic      [NMioPads-1:0]  mio_in_o,
  pad_drive_if.mio_src              drive
);

  logic [GpioWidth-1:0] gpio_d;
  logic [GpioWidth-1:0] gpio_en;
  logic [GpioWidth-1:0] gpio_pull_en;
  logic [GpioWidth-1:0] gpio_pull_sel;

  // core -> pad, pulls collected in gpio bit order
  always_comb begin
    gpio_d        = '0;
    gpio_en       = '0;
    gpio_pull_en  = '0;
    gpio_pull_sel = '0;
    for (int i = 0; i < GpioWidth; i++) begin
      if (GpioUsedMask[i]) begin
        gpio_d[i]        = mio_out_i[GpioPadIdx[i]];
        gpio_en[i]       = mio_oe_i[GpioPadIdx[i]];
        gpio_pull_en[i]  = mio_attr_i[GpioPadIdx[i]].pull_en;
        gpio_pull_sel[i] = mio_attr_i[GpioPadIdx[i]].pull_select;
      end
    end
  end

  assign drive.gpio_d        = gpio_d;
  assign drive.gpio_en       = gpio_en;
  assign drive.gpio_pull_en  = gpio_pull_en;
  assign drive.gpio_pull_sel = gpio_pull_sel;

  assign drive.uart_tx    = mio_out_i[MioPadIoc4];
  assign drive.uart_tx_en = mio_oe_i[MioPadIoc4];

  // pad -> core, unrouted pads read 0
  always_comb begin
    mio_in_o = '0;
    for (int i = 0; i < GpioWidth; i++) begin
      if (GpioUsedMask[i]) begin
        mio_in_o[GpioPadIdx[i]] = gpio_p2d_i[i];
      end
    end
    mio_in_o[MioPadIoc3] = uart_rx_p2d_i;
    // vbus sense
    mio_in_o[MioPadIoc7] = usb_sense_p2d_i;
  end

endmodule

// File: rtl/dio_pad_map.sv
/*
 * dedicated pad routing for spi device and usb, both directions
 */
`timescale 1ns/1ps

module dio_pad_map import chip_pkg::*; (
  input  logic [NDioPads-1:0] dio_out_i,
  input  logic [NDioPads-1:0] dio_oe_i,
  input  logic                usb_tx_d_i,
  input  logic                spi_sck_p2d_i,
  input  logic                spi_csb_p2d_i,
  input  logic                spi_sdi_p2d_i,
  input  logic                usb_dp_p2d_i,
  input  logic                usb_dn_p2d_i,
  input  logic                usb_d_p2d_i,
  output logic [NDioPads-1:0] dio_in_o,
  output logic                usb_rx_d_o,
  pad_drive_if.dio_src        drive
);

  // spi sdo rides on sd1
  assign drive.spi_sdo    = dio_out_i[DioSpiSd1];
  assign drive.spi_sdo_en = dio_oe_i[DioSpiSd1];

  assign drive.usb_dp    = dio_out_i[DioUsbDp];
  assign drive.usb_dp_en = dio_oe_i[DioUsbDp];
  assign drive.usb_dn    = dio_out_i[DioUsbDn];
  assign drive.usb_dn_en = dio_oe_i[DioUsbDn];

  // single-ended data shares the dp enable
  assign drive.usb_d_en = dio_oe_i[DioUsbDp];

  always_comb begin
    dio_in_o = '0;
    dio_in_o[DioSpiSck] = spi_sck_p2d_i;
    dio_in_o[DioSpiCsb] = spi_csb_p2d_i;
    dio_in_o[DioSpiSd0] = spi_sdi_p2d_i;
    dio_in_o[DioUsbDp]  = usb_dp_p2d_i;
    dio_in_o[DioUsbDn]  = usb_dn_p2d_i;
  end

  assign usb_rx_d_o = usb_d_p2d_i;

endmodule

// File: rtl/por_supply_seq.sv
/*
 * fake supply ramp with a dip, always-on and main power-ok generation
 */
`timescale 1ns/1ps

module por_supply_seq import chip_pkg::*; (
  input  logic       clk_aon,
  input  logic       arst_n_i,
  output logic       main_pok_o,
  output logic [1:0] por_n_o
);

  logic [3:0] supply_cnt;
  por_phase_e phase;
  logic       supply_on;
  logic       aon_pok;
  logic [3:0] settle_cnt;

  // count up and stick at the top
  always_ff @(posedge clk_aon or negedge arst_n_i) begin
    if (!arst_n_i) begin
      supply_cnt <= '0;
    end else if (supply_cnt < 4'(PorCntMax)) begin
      supply_cnt <= supply_cnt + 4'd1;
    end
  end

  always_comb begin
    if (supply_cnt < 4'(SupplyRiseCnt)) begin
      phase = PHASE_RAMP;
    end else if (supply_cnt < 4'(SupplyDipStart)) begin
      phase = PHASE_FIRST_ON;
    end else if (supply_cnt < 4'(SupplyDipEnd)) begin
      phase = PHASE_DIP;
    end else begin
      phase = PHASE_STABLE;
    end
  end

  assign supply_on = (phase == PHASE_FIRST_ON) || (phase == PHASE_STABLE);

  //////////////////////////////////////////////////
  // pok generation
  //////////////////////////////////////////////////
  // settle count restarts on any aon drop
  always_ff @(posedge clk_aon or negedge arst_n_i) begin
    if (!arst_n_i) begin
      aon_pok    <= 1'b0;
      settle_cnt <= '0;
    end else begin
      aon_pok <= supply_on;
      if (!aon_pok) begin
        settle_cnt <= '0;
      end else if (settle_cnt < 4'(MainPokDelay)) begin
        settle_cnt <= settle_cnt + 4'd1;
      end
    end
  end

  // main drops in the same cycle as aon
  assign main_pok_o = aon_pok && (settle_cnt >= 4'(MainPokDelay));
  assign por_n_o    = {main_pok_o, aon_pok};

endmodule

// File: rtl/pad_output_gate.sv
/*
 * holds every pad drive, enable and pull at 0 until main power is ok
 */
`timescale 1ns/1ps

module pad_output_gate import chip_pkg::*; (
  input  logic                 main_pok_i,
  pad_drive_if.gate            drive,
  output logic [GpioWidth-1:0] gpio_d2p_o,
  output logic [GpioWidth-1:0] gpio_en_d2p_o,
  output logic [GpioWidth-1:0] gpio_pull_en_o,
  output logic [GpioWidth-1:0] gpio_pull_select_o,
  output logic                 uart_tx_d2p_o,
  output logic                 uart_tx_en_d2p_o,
  output logic                 spi_sdo_d2p_o,
  output logic                 spi_sdo_en_d2p_o,
  output logic                 usb_dp_d2p_o,
  output logic                 usb_dp_en_d2p_o,
  output logic                 usb_dn_d2p_o,
  output logic                 usb_dn_en_d2p_o,
  output logic                 usb_d_d2p_o,
  output logic                 usb_d_en_d2p_o,
  input  logic                 usb_tx_d_i
);

  logic [GpioWidth-1:0] gpio_keep;

  assign gpio_keep = {GpioWidth{main_pok_i}};

  // gpio pads
  assign gpio_d2p_o         = gpio_keep & drive.gpio_d;
  assign gpio_en_d2p_o      = gpio_keep & drive.gpio_en;
  assign gpio_pull_en_o     = gpio_keep & drive.gpio_pull_en;
  assign gpio_pull_select_o = gpio_keep & drive.gpio_pull_sel;

  // uart and spi
  assign uart_tx_d2p_o    = main_pok_i & drive.uart_tx;
  assign uart_tx_en_d2p_o = main_pok_i & drive.uart_tx_en;
  assign spi_sdo_d2p_o    = main_pok_i & drive.spi_sdo;
  assign spi_sdo_en_d2p_o = main_pok_i & drive.spi_sdo_en;

  // usb differential and single-ended
  assign usb_dp_d2p_o    = main_pok_i & drive.usb_dp;
  assign usb_dp_en_d2p_o = main_pok_i & drive.usb_dp_en;
  assign usb_dn_d2p_o    = main_pok_i & drive.usb_dn;
  assign usb_dn_en_d2p_o = main_pok_i & drive.usb_dn_en;
  assign usb_d_d2p_o     = main_pok_i & usb_tx_d_i;
  assign usb_d_en_d2p_o  = main_pok_i & drive.usb_d_en;

endmodule

// File: rtl/chip_padring.sv
/*
 * chip pad ring top: mio and dio maps, power-on sequencer, output gate
 */
`timescale 1ns/1ps

module chip_padring import chip_pkg::*; (
  input  logic                      clk_aon,
  input  logic                      arst_n_i,

  // core side, multiplexed pads
  input  logic      [NMioPads-1:0]  mio_out_i,
  input  logic      [NMioPads-1:0]  mio_oe_i,
  input  pad_attr_t [NMioPads-1:0]  mio_attr_i,
  output logic      [NMioPads-1:0]  mio_in_o,

  // core side, dedicated pads
  input  logic      [NDioPads-1:0]  dio_out_i,
  input  logic      [NDioPads-1:0]  dio_oe_i,
  output logic      [NDioPads-1:0]  dio_in_o,
  input  logic                      usb_tx_d_i,
  output logic                      usb_rx_d_o,

  // gpio pads
  input  logic      [GpioWidth-1:0] gpio_p2d_i,
  output logic      [GpioWidth-1:0] gpio_d2p_o,
  output logic      [GpioWidth-1:0] gpio_en_d2p_o,
  output logic      [GpioWidth-1:0] gpio_pull_en_o,
  output logic      [GpioWidth-1:0] gpio_pull_select_o,

  // uart pads
  input  logic                      uart_rx_p2d_i,
  output logic                      uart_tx_d2p_o,
  output logic                      uart_tx_en_d2p_o,

  // spi device pads
  input  logic                      spi_sck_p2d_i,
  input  logic                      spi_csb_p2d_i,
  input  logic                      spi_sdi_p2d_i,
  output logic                      spi_sdo_d2p_o,
  output logic                      spi_sdo_en_d2p_o,

  // usb pads
  input  logic                      usb_sense_p2d_i,
  input  logic                      usb_dp_p2d_i,
  input  logic                      usb_dn_p2d_i,
  input  logic                      usb_d_p2d_i,
  output logic                      usb_dp_d2p_o,
  output logic                      usb_dp_en_d2p_o,
  output logic                      usb_dn_d2p_o,
  output logic                      usb_dn_en_d2p_o,
  output logic                      usb_d_d2p_o,
  output logic                      usb_d_en_d2p_o,

  // {main_pok, aon_pok}
  output logic      [1:0]           por_n_o
);

  logic        main_pok;
  pad_drive_if pad_drive ();

  //////////////////////////////////////////////////
  // pad maps
  //////////////////////////////////////////////////
  mio_pad_map u_mio_map (
    .mio_out_i       (mio_out_i),
    .mio_oe_i        (mio_oe_i),
    .mio_attr_i      (mio_attr_i),
    .gpio_p2d_i      (gpio_p2d_i),
    .uart_rx_p2d_i   (uart_rx_p2d_i),
    .usb_sense_p2d_i (usb_sense_p2d_i),
    .mio_in_o        (mio_in_o),
    .drive           (pad_drive.mio_src)
  );

  dio_pad_map u_dio_map (
    .dio_out_i     (dio_out_i),
    .dio_oe_i      (dio_oe_i),
    .usb_tx_d_i    (usb_tx_d_i),
    .spi_sck_p2d_i (spi_sck_p2d_i),
    .spi_csb_p2d_i (spi_csb_p2d_i),
    .spi_sdi_p2d_i (spi_sdi_p2d_i),
    .usb_dp_p2d_i  (usb_dp_p2d_i),
    .usb_dn_p2d_i  (usb_dn_p2d_i),
    .usb_d_p2d_i   (usb_d_p2d_i),
    .dio_in_o      (dio_in_o),
    .usb_rx_d_o    (usb_rx_d_o),
    .drive         (pad_drive.dio_src)
  );

  //////////////////////////////////////////////////
  // power-on and output gating
  //////////////////////////////////////////////////
  por_supply_seq u_por_seq (
    .clk_aon    (clk_aon),
    .arst_n_i   (arst_n_i),
    .main_pok_o (main_pok),
    .por_n_o    (por_n_o)
  );

  pad_output_gate u_out_gate (
    .main_pok_i         (main_pok),
    .drive              (pad_drive.gate),
    .gpio_d2p_o         (gpio_d2p_o),
    .gpio_en_d2p_o      (gpio_en_d2p_o),
    .gpio_pull_en_o     (gpio_pull_en_o),
    .gpio_pull_select_o (gpio_pull_select_o),
    .uart_tx_d2p_o      (uart_tx_d2p_o),
    .uart_tx_en_d2p_o   (uart_tx_en_d2p_o),
    .spi_sdo_d2p_o      (spi_sdo_d2p_o),
    .spi_sdo_en_d2p_o   (spi_sdo_en_d2p_o),
    .usb_dp_d2p_o       (usb_dp_d2p_o),
    .usb_dp_en_d2p_o    (usb_dp_en_d2p_o),
    .usb_dn_d2p_o       (usb_dn_d2p_o),
    .usb_dn_en_d2p_o    (usb_dn_en_d2p_o),
    .usb_d_d2p_o        (usb_d_d2p_o),
    .usb_d_en_d2p_o     (usb_d_en_d2p_o),
    .usb_tx_d_i         (usb_tx_d_i)
  );

endmodule

// File: tests/tb_chip_padring.sv
/*
 * testbench for the chip pad ring: random core and pad stimulus,
 * power-on schedule, pad routing and output gating checks
 */
`timescale 1ns/1ps

module tb_chip_padring import chip_pkg::*; ();

  logic                      clk_aon;
  logic                      arst_n_i;
  logic      [NMioPads-1:0]  mio_out_i;
  logic      [NMioPads-1:0]  mio_oe_i;
  pad_attr_t [NMioPads-1:0]  mio_attr_i;
  logic      [NMioPads-1:0]  mio_in_o;
  logic      [NDioPads-1:0]  dio_out_i;
  logic      [NDioPads-1:0]  dio_oe_i;
  logic      [NDioPads-1:0]  dio_in_o;
  logic                      usb_tx_d_i;
  logic                      usb_rx_d_o;
  logic      [GpioWidth-1:0] gpio_p2d_i;
  logic      [GpioWidth-1:0] gpio_d2p_o;
  logic      [GpioWidth-1:0] gpio_en_d2p_o;
  logic      [GpioWidth-1:0] gpio_pull_en_o;
  logic      [GpioWidth-1:0] gpio_pull_select_o;
  logic                      uart_rx_p2d_i;
  logic                      uart_tx_d2p_o;
  logic                      uart_tx_en_d2p_o;
  logic                      spi_sck_p2d_i;
  logic                      spi_csb_p2d_i;
  logic                      spi_sdi_p2d_i;
  logic                      spi_sdo_d2p_o;
  logic                      spi_sdo_en_d2p_o;
  logic                      usb_sense_p2d_i;
  logic                      usb_dp_p2d_i;
  logic                      usb_dn_p2d_i;
  logic                      usb_d_p2d_i;
  logic                      usb_dp_d2p_o;
  logic                      usb_dp_en_d2p_o;
  logic                      usb_dn_d2p_o;
  logic                      usb_dn_en_d2p_o;
  logic                      usb_d_d2p_o;
  logic                      usb_d_en_d2p_o;
  logic      [1:0]           por_n_o;

  integer seed;
  int     err_cnt;
  int     edge_cnt;
  int     cycle_cnt;

  chip_padring dut_i (.*);

  always #50 clk_aon = ~clk_aon;

  // edges since reset release
  always @(posedge clk_aon or negedge arst_n_i) begin
    if (!arst_n_i) begin
      edge_cnt <= 0;
    end else begin
      edge_cnt <= edge_cnt + 1;
    end
  end

  //////////////////////////////////////////////////
  // reference pad table and helpers
  //////////////////////////////////////////////////
  // mio pad of a gpio bit (-1 if unrouted)
  function automatic int gpio_pad_of(int b);
    if (b <= 6) return 13 + b;
    else if (b <= 9) return 37 + b - 7;
    else if (b <= 13) return 40 + b - 10;
    else if (b >= 22 && b <= 24) return b;
    else if (b == 27 || b == 30) return b;
    else return -1;
  endfunction

  task automatic flag_mismatch(string msg);
    $display("FAIL %0t: %s", $time, msg);
    err_cnt++;
  endtask

  task automatic drive_random_inputs();
    logic [95:0] rnd;
    rnd = {$random(seed), $random(seed), $random(seed)};
    mio_out_i = rnd[NMioPads-1:0];
    mio_oe_i  = rnd[2*NMioPads-1:NMioPads];
    rnd = {$random(seed), $random(seed), $random(seed)};
    mio_attr_i = rnd[2*NMioPads-1:0];
    rnd = {$random(seed), $random(seed), $random(seed)};
    dio_out_i       = rnd[15:0];
    dio_oe_i        = rnd[31:16];
    gpio_p2d_i      = rnd[63:32];
    usb_tx_d_i      = rnd[64];
    uart_rx_p2d_i   = rnd[65];
    spi_sck_p2d_i   = rnd[66];
    spi_csb_p2d_i   = rnd[67];
    spi_sdi_p2d_i   = rnd[68];
    usb_sense_p2d_i = rnd[69];
    usb_dp_p2d_i    = rnd[70];
    usb_dn_p2d_i    = rnd[71];
    usb_d_p2d_i     = rnd[72];
  endtask

  task automatic check_outputs();
    logic [NMioPads-1:0]  exp_mio_in;
    logic [NDioPads-1:0]  exp_dio_in;
    logic [GpioWidth-1:0] exp_d, exp_en, exp_pe, exp_ps;
    logic [9:0]           exp_pads, got_pads;
    logic                 aon_exp, main_exp;
    int                   pad;
    aon_exp  = (edge_cnt >= 5 && edge_cnt <= 8) || edge_cnt >= 13;
    main_exp = edge_cnt >= 21;
    exp_mio_in = '0;
    exp_d      = '0;
    exp_en     = '0;
    exp_pe     = '0;
    exp_ps     = '0;
    for (int b = 0; b < GpioWidth; b++) begin
      pad = gpio_pad_of(b);
      if (pad >= 0) begin
        exp_mio_in[pad] = gpio_p2d_i[b];
        exp_d[b]  = mio_out_i[pad];
        exp_en[b] = mio_oe_i[pad];
        exp_pe[b] = mio_attr_i[pad].pull_en;
        exp_ps[b] = mio_attr_i[pad].pull_select;
      end
    end
    // gpio pads stay quiet until main power-ok
    exp_d  = exp_d & {GpioWidth{main_exp}};
    exp_en = exp_en & {GpioWidth{main_exp}};
    exp_pe = exp_pe & {GpioWidth{main_exp}};
    exp_ps = exp_ps & {GpioWidth{main_exp}};
    exp_mio_in[25] = uart_rx_p2d_i;
    exp_mio_in[29] = usb_sense_p2d_i;
    exp_dio_in = '0;
    exp_dio_in[12] = spi_sck_p2d_i;
    exp_dio_in[13] = spi_csb_p2d_i;
    exp_dio_in[14] = spi_sdi_p2d_i;
    exp_dio_in[1]  = usb_dp_p2d_i;
    exp_dio_in[0]  = usb_dn_p2d_i;
    // data and enable pairs of uart tx, spi sdo, usb dp, dn and single-ended
    exp_pads = {mio_out_i[26], mio_oe_i[26], dio_out_i[15], dio_oe_i[15],
                dio_out_i[1], dio_oe_i[1], dio_out_i[0], dio_oe_i[0],
                usb_tx_d_i, dio_oe_i[1]} & {10{main_exp}};
    got_pads = {uart_tx_d2p_o, uart_tx_en_d2p_o, spi_sdo_d2p_o, spi_sdo_en_d2p_o,
                usb_dp_d2p_o, usb_dp_en_d2p_o, usb_dn_d2p_o, usb_dn_en_d2p_o,
                usb_d_d2p_o, usb_d_en_d2p_o};

    assert (por_n_o == {main_exp, aon_exp})
      else flag_mismatch($sformatf("por_n_o %b, expected %b", por_n_o, {main_exp, aon_exp}));
    assert (mio_in_o == exp_mio_in)
      else flag_mismatch($sformatf("mio_in_o %h, expected %h", mio_in_o, exp_mio_in));
    assert (dio_in_o == exp_dio_in)
      else flag_mismatch($sformatf("dio_in_o %h, expected %h", dio_in_o, exp_dio_in));
    assert (usb_rx_d_o == usb_d_p2d_i)
      else flag_mismatch($sformatf("usb_rx_d_o %b, expected %b", usb_rx_d_o, usb_d_p2d_i));
    assert (gpio_d2p_o == exp_d)
      else flag_mismatch($sformatf("gpio_d2p_o %h, expected %h", gpio_d2p_o, exp_d));
    assert (gpio_en_d2p_o == exp_en)
      else flag_mismatch($sformatf("gpio_en_d2p_o %h, expected %h", gpio_en_d2p_o, exp_en));
    assert (gpio_pull_en_o == exp_pe)
      else flag_mismatch($sformatf("gpio_pull_en_o %h, expected %h", gpio_pull_en_o, exp_pe));
    assert (gpio_pull_select_o == exp_ps)
      else flag_mismatch($sformatf("gpio_pull_select_o %h, expected %h",
                                   gpio_pull_select_o, exp_ps));
    assert (got_pads == exp_pads)
      else flag_mismatch($sformatf("uart/spi/usb pads %b, expected %b", got_pads, exp_pads));
  endtask

  //////////////////////////////////////////////////
  // stimulus, checking and run control
  //////////////////////////////////////////////////
  always @(posedge clk_aon) begin
    #5;
    drive_random_inputs();
  end

  // mid-cycle sample
  always @(negedge clk_aon) check_outputs();

  always @(posedge clk_aon) begin
    cycle_cnt++;
    if (cycle_cnt >= 200) begin
      $display("timeout: run did not complete within 200 cycles");
      $display("Done: errors found");
      $finish;
    end
  end

  initial begin
    seed            = 32'h45d9d2e2;
    err_cnt         = 0;
    cycle_cnt       = 0;
    clk_aon         = 1'b0;
    arst_n_i        = 1'b0;
    mio_out_i       = '0;
    mio_oe_i        = '0;
    mio_attr_i      = '0;
    dio_out_i       = '0;
    dio_oe_i        = '0;
    usb_tx_d_i      = 1'b0;
    gpio_p2d_i      = '0;
    uart_rx_p2d_i   = 1'b0;
    spi_sck_p2d_i   = 1'b0;
    spi_csb_p2d_i   = 1'b0;
    spi_sdi_p2d_i   = 1'b0;
    usb_sense_p2d_i = 1'b0;
    usb_dp_p2d_i    = 1'b0;
    usb_dn_p2d_i    = 1'b0;
    usb_d_p2d_i     = 1'b0;
    repeat (4) @(posedge clk_aon);
    #5 arst_n_i = 1'b1;
    // gated phase runs until main power-ok
    while (!por_n_o[1]) @(posedge clk_aon);
    repeat (150) @(posedge clk_aon);
    $display("errors: %0d", err_cnt);
    if (err_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: filelist.f
rtl/chip_pkg.sv
rtl/pad_drive_if.sv
rtl/mio_pad_map.sv
rtl/dio_pad_map.sv
rtl/por_supply_seq.sv
rtl/pad_output_gate.sv
rtl/chip_padring.sv
tests/tb_chip_padring.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --top-module tb_chip_padring -f filelist.f
	./obj_dir/Vtb_chip_padring > sim.log
	cat sim.log
	! grep -q "Done: errors found" sim.log

clean:
	rm -rf obj_dir sim.log
